// ==== mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

    // ==========================================================
    // list memory geometry.
    // ==========================================================

    // address width shared by all list memories.
    localparam int MEM_AW    = 6;
    localparam int MEM_DEPTH = 1 << MEM_AW;

    // freelist and history-list payload widths.
    localparam int FL_DW     = 16;
    localparam int HL_DW     = 40;

    localparam int FL_NUM    = 2;

    // ==========================================================
    // port request words.
    // ==========================================================

    // one freelist access, 24 bits.
    typedef struct packed {
        logic [MEM_AW-1:0] addr;
        logic              we;
        logic              re;
        logic [FL_DW-1:0]  wdata;
    } fl_req_t;

    // one history-list access, 48 bits.
    typedef struct packed {
        logic [MEM_AW-1:0] addr;
        logic              we;
        logic              re;
        logic [HL_DW-1:0]  wdata;
    } hl_req_t;

endpackage

`default_nettype wire

// ==== pg_pkg.sv ====
`default_nettype none

package pg_pkg;

    // ==========================================================
    // power switch timing.
    // ==========================================================

    // cycles of steady low request before the switch chain
    // reports itself on. Power-down does not wait.
    localparam int PG_WAKE_CYCLES = 4;

    // wake counter width, must hold PG_WAKE_CYCLES itself.
    localparam int PG_CNT_W       = 3;

    // ==========================================================
    // power-gate controls of one memory.
    // ==========================================================

    // both fields are levels from the power-gate controller.
    // isol_en clamps the memory outputs and blocks access.
    // pwr_enable_b is the active low switch request.
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } pg_ctl_t;

endpackage

`default_nettype wire

// ==== pg_switch_seq.sv ====
`default_nettype none

module pg_switch_seq import pg_pkg::*; (
     input  logic i_clk
    ,input  logic i_rst
    ,input  logic i_pwr_enable_b
    ,output logic o_pwr_enable_b
);

    logic [PG_CNT_W-1:0] wake_cnt;
    logic                pwr_b_q;
    logic                wake_done;

    // staged turn-on of the switch chain ends here.
    assign wake_done = (wake_cnt == PG_CNT_W'(PG_WAKE_CYCLES));

    // ==========================================================
    // wake counter.
    // ==========================================================

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wake_cnt <= '0;
            pwr_b_q  <= 1'b1;
        end else if (i_pwr_enable_b) begin
            // power-down, also restarts an unfinished wake.
            wake_cnt <= '0;
            pwr_b_q  <= 1'b1;
        end else if (pwr_b_q) begin
            if (wake_done) begin
                pwr_b_q <= 1'b0;
            end else begin
                wake_cnt <= wake_cnt + 1'b1;
            end
        end
    end

    assign o_pwr_enable_b = pwr_b_q;

    // ==========================================================
    // checks.
    // ==========================================================

    // a falling output needs the whole wake window of low requests.
    a_no_early_wake: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $fell(o_pwr_enable_b) |->
            !$past(i_pwr_enable_b, 1) && !$past(i_pwr_enable_b, PG_WAKE_CYCLES + 1)
    );

endmodule

`default_nettype wire

// ==== mem_pg_sram.sv ====
`default_nettype none

module mem_pg_sram import mem_cfg_pkg::*, pg_pkg::*; #(
     parameter int MEM_AW_P = MEM_AW
    ,parameter int DATA_W   = FL_DW
) (
     input  logic                i_clk
    ,input  logic                i_rst
    ,input  logic                i_pwrgood_rst_b
    ,input  logic [MEM_AW_P-1:0] i_addr
    ,input  logic                i_we
    ,input  logic                i_re
    ,input  logic [DATA_W-1:0]   i_wdata
    ,input  pg_ctl_t             i_pg
    ,output logic [DATA_W-1:0]   o_rdata
    ,output logic                o_pwr_enable_b
);

    logic                     rst;
    logic                     pwr_b;
    logic                     powered;
    logic                     access_ok;
    logic [DATA_W-1:0]        mem [2**MEM_AW_P];
    logic [2**MEM_AW_P-1:0]   valid;
    logic [DATA_W-1:0]        rdata_q;

    // either reset source puts the memory in its off state.
    assign rst       = i_rst | ~i_pwrgood_rst_b;
    assign powered   = ~pwr_b;
    assign access_ok = powered & ~i_pg.isol_en;

    pg_switch_seq i_pg_seq (
         .i_clk          (i_clk)
        ,.i_rst          (rst)
        ,.i_pwr_enable_b (i_pg.pwr_enable_b)
        ,.o_pwr_enable_b (pwr_b)
    );

    // ==========================================================
    // storage.
    // ==========================================================

    always_ff @(posedge i_clk) begin
        if (i_we && access_ok) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // contents are lost on every unpowered cycle.
    always_ff @(posedge i_clk) begin
        if (rst || !powered) begin
            valid <= '0;
        end else if (i_we && !i_pg.isol_en) begin
            valid[i_addr] <= 1'b1;
        end
    end

    // ==========================================================
    // read port.
    // ==========================================================

    // read before write on a shared address.
    always_ff @(posedge i_clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (i_re) begin
            rdata_q <= (access_ok && valid[i_addr]) ? mem[i_addr] : '0;
        end
    end

    // output clamp.
    assign o_rdata        = access_ok ? rdata_q : '0;
    assign o_pwr_enable_b = pwr_b;

    // ==========================================================
    // checks.
    // ==========================================================

    // a write under isolation leaves the addressed entry as it was.
    a_isol_no_write: assert property (
        @(posedge i_clk) disable iff (rst)
        (i_we && i_pg.isol_en) |=> (mem[$past(i_addr)] === $past(mem[i_addr]))
    );

    // an isolated read sees zero now and registers zero for later.
    a_isol_rdata_zero: assert property (
        @(posedge i_clk) disable iff (rst)
        (i_re && i_pg.isol_en) |-> (o_rdata == '0) ##1 (o_rdata == '0)
    );

endmodule

`default_nettype wire

// ==== sram_pg_cont.sv ====
`default_nettype none

module sram_pg_cont import mem_cfg_pkg::*, pg_pkg::*; (
     input  logic                i_clk
    ,input  logic                i_rst
    ,input  logic                i_pwrgood_rst_b

    ,input  fl_req_t             i_fl_req [FL_NUM]
    ,input  pg_ctl_t             i_fl_pg [FL_NUM]
    ,output logic [FL_DW-1:0]    o_fl_rdata [FL_NUM]
    ,output logic [FL_NUM-1:0]   o_fl_pwr_enable_b

    ,input  hl_req_t             i_hl_req
    ,input  pg_ctl_t             i_hl_pg
    ,output logic [HL_DW-1:0]    o_hl_rdata
    ,output logic                o_hl_pwr_enable_b
);

    // ==========================================================
    // freelist memories.
    // ==========================================================

    for (genvar g = 0; g < FL_NUM; g++) begin : g_fl

        mem_pg_sram #(
             .MEM_AW_P        (MEM_AW)
            ,.DATA_W          (FL_DW)
        ) i_sr_freelist (
             .i_clk           (i_clk)
            ,.i_rst           (i_rst)
            ,.i_pwrgood_rst_b (i_pwrgood_rst_b)

            ,.i_addr          (i_fl_req[g].addr)
            ,.i_we            (i_fl_req[g].we)
            ,.i_re            (i_fl_req[g].re)
            ,.i_wdata         (i_fl_req[g].wdata)
            ,.o_rdata         (o_fl_rdata[g])

            ,.i_pg            (i_fl_pg[g])
            ,.o_pwr_enable_b  (o_fl_pwr_enable_b[g])
        );

    end

    // ==========================================================
    // history-list memory.
    // ==========================================================

    // wider payload, same port behavior.
    mem_pg_sram #(
         .MEM_AW_P        (MEM_AW)
        ,.DATA_W          (HL_DW)
    ) i_sr_hist_list (
         .i_clk           (i_clk)
        ,.i_rst           (i_rst)
        ,.i_pwrgood_rst_b (i_pwrgood_rst_b)

        ,.i_addr          (i_hl_req.addr)
        ,.i_we            (i_hl_req.we)
        ,.i_re            (i_hl_req.re)
        ,.i_wdata         (i_hl_req.wdata)
        ,.o_rdata         (o_hl_rdata)

        ,.i_pg            (i_hl_pg)
        ,.o_pwr_enable_b  (o_hl_pwr_enable_b)
    );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker import mem_cfg_pkg::*, pg_pkg::*; (
     input  logic              i_clk
    ,input  logic              i_rst
    ,input  logic              i_pwrgood_rst_b
    ,input  fl_req_t           i_fl_req [FL_NUM]
    ,input  pg_ctl_t           i_fl_pg [FL_NUM]
    ,input  logic [FL_DW-1:0]  i_fl_rdata [FL_NUM]
    ,input  logic [FL_NUM-1:0] i_fl_pwr_enable_b
    ,input  hl_req_t           i_hl_req
    ,input  pg_ctl_t           i_hl_pg
    ,input  logic [HL_DW-1:0]  i_hl_rdata
    ,input  logic              i_hl_pwr_enable_b
    ,input  logic              i_test_end
    ,input  int                i_test_id
    ,input  int                i_timeouts
    ,output int                o_errors
    ,output int                o_checks
);

    // model state, one slot per memory, history list last.
    logic [HL_DW-1:0]     m_data  [FL_NUM+1][MEM_DEPTH];
    logic [MEM_DEPTH-1:0] m_valid [FL_NUM+1];
    logic [HL_DW-1:0]     m_rq    [FL_NUM+1];
    logic                 m_pwr_b [FL_NUM+1];
    int                   m_low   [FL_NUM+1];
    logic                 started   = 1'b0;
    int                   errors    = 0;
    int                   checks    = 0;
    int                   test_base = 0;

    assign o_errors = errors;
    assign o_checks = checks;

    // ==========================================================
    // port views, widened to the history-list word.
    // ==========================================================

    function automatic hl_req_t req_of(input int m);
        hl_req_t r;
        if (m < FL_NUM) begin
            r.addr  = i_fl_req[m].addr;
            r.we    = i_fl_req[m].we;
            r.re    = i_fl_req[m].re;
            r.wdata = {{(HL_DW-FL_DW){1'b0}}, i_fl_req[m].wdata};
        end else begin
            r = i_hl_req;
        end
        return r;
    endfunction

    function automatic pg_ctl_t pg_of(input int m);
        return (m < FL_NUM) ? i_fl_pg[m] : i_hl_pg;
    endfunction

    function automatic logic [HL_DW-1:0] rdata_of(input int m);
        return (m < FL_NUM) ? {{(HL_DW-FL_DW){1'b0}}, i_fl_rdata[m]} : i_hl_rdata;
    endfunction

    function automatic logic pwr_of(input int m);
        return (m < FL_NUM) ? i_fl_pwr_enable_b[m] : i_hl_pwr_enable_b;
    endfunction

    // ==========================================================
    // reference.
    // ==========================================================

    // an entry reads back only when powered, open and written since power-up.
    function automatic logic [HL_DW-1:0] ref_read(input int m, input hl_req_t req,
                                                   input pg_ctl_t pg);
        if (m_pwr_b[m] || pg.isol_en || !m_valid[m][req.addr]) begin
            return '0;
        end
        return m_data[m][req.addr];
    endfunction

    // held read word behind the output clamp.
    function automatic logic [HL_DW-1:0] exp_rdata(input int m, input pg_ctl_t pg);
        if (m_pwr_b[m] || pg.isol_en) begin
            return '0;
        end
        return m_rq[m];
    endfunction

    task automatic compare_word(input string name, input logic [HL_DW-1:0] got,
                                input logic [HL_DW-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    // ==========================================================
    // compare, then step the model by the inputs of the next edge.
    // ==========================================================

    always @(negedge i_clk) begin : b_model
        hl_req_t req;
        pg_ctl_t pg;
        logic    rst;
        int      fails;
        string   rd_name;
        string   pw_name;
        rst = i_rst || !i_pwrgood_rst_b;
        for (int m = 0; m < FL_NUM + 1; m++) begin
            req = req_of(m);
            pg  = pg_of(m);
            if (m < FL_NUM) begin
                rd_name = $sformatf("o_fl_rdata[%0d]", m);
                pw_name = $sformatf("o_fl_pwr_enable_b[%0d]", m);
            end else begin
                rd_name = "o_hl_rdata";
                pw_name = "o_hl_pwr_enable_b";
            end
            if (started) begin
                compare_word(rd_name, rdata_of(m), exp_rdata(m, pg));
                compare_word(pw_name, {{(HL_DW-1){1'b0}}, pwr_of(m)},
                             {{(HL_DW-1){1'b0}}, m_pwr_b[m]});
            end
            if (rst) begin
                m_rq[m]    = '0;
                m_valid[m] = '0;
                m_low[m]   = 0;
                m_pwr_b[m] = 1'b1;
            end else begin
                // old contents first, so a same-cycle write is not seen.
                if (req.re) begin
                    m_rq[m] = ref_read(m, req, pg);
                end
                if (m_pwr_b[m]) begin
                    m_valid[m] = '0;
                end else if (req.we && !pg.isol_en) begin
                    m_data[m][req.addr]  = req.wdata;
                    m_valid[m][req.addr] = 1'b1;
                end
                // the switch reports on after the wake window of low samples.
                if (pg.pwr_enable_b) begin
                    m_low[m] = 0;
                end else if (m_low[m] <= PG_WAKE_CYCLES) begin
                    m_low[m]++;
                end
                m_pwr_b[m] = (m_low[m] <= PG_WAKE_CYCLES);
            end
        end
        if (rst) begin
            started = 1'b1;
        end
        if (i_test_end) begin
            fails     = errors + i_timeouts - test_base;
            test_base = errors + i_timeouts;
            $display("test %0d: %s, %0d failures", i_test_id,
                     (fails == 0) ? "ok" : "FAILED", fails);
        end
    end

endmodule

`default_nettype wire

// ==== tb_sram_pg_cont.sv ====
`default_nettype none

module tb_sram_pg_cont import mem_cfg_pkg::*, pg_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              pwrgood_rst_b;
    fl_req_t           fl_req [FL_NUM];
    pg_ctl_t           fl_pg [FL_NUM];
    logic [FL_DW-1:0]  fl_rdata [FL_NUM];
    logic [FL_NUM-1:0] fl_pwr_b;
    hl_req_t           hl_req;
    pg_ctl_t           hl_pg;
    logic [HL_DW-1:0]  hl_rdata;
    logic              hl_pwr_b;

    logic              test_end;
    int                test_id;
    int                timeouts;
    int                errors;
    int                checks;
    int                seed;
    logic [MEM_AW-1:0] addrs [FL_NUM+1][8];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    sram_pg_cont i_sram_pg_cont (
         .i_clk             (clk)
        ,.i_rst             (rst)
        ,.i_pwrgood_rst_b   (pwrgood_rst_b)
        ,.i_fl_req          (fl_req)
        ,.i_fl_pg           (fl_pg)
        ,.o_fl_rdata        (fl_rdata)
        ,.o_fl_pwr_enable_b (fl_pwr_b)
        ,.i_hl_req          (hl_req)
        ,.i_hl_pg           (hl_pg)
        ,.o_hl_rdata        (hl_rdata)
        ,.o_hl_pwr_enable_b (hl_pwr_b)
    );

    tb_checker i_tb_checker (
         .i_clk             (clk)
        ,.i_rst             (rst)
        ,.i_pwrgood_rst_b   (pwrgood_rst_b)
        ,.i_fl_req          (fl_req)
        ,.i_fl_pg           (fl_pg)
        ,.i_fl_rdata        (fl_rdata)
        ,.i_fl_pwr_enable_b (fl_pwr_b)
        ,.i_hl_req          (hl_req)
        ,.i_hl_pg           (hl_pg)
        ,.i_hl_rdata        (hl_rdata)
        ,.i_hl_pwr_enable_b (hl_pwr_b)
        ,.i_test_end        (test_end)
        ,.i_test_id         (test_id)
        ,.i_timeouts        (timeouts)
        ,.o_errors          (errors)
        ,.o_checks          (checks)
    );

    // ==========================================================
    // stimulus helpers. Memory index FL_NUM is the history list.
    // ==========================================================

    function automatic logic [HL_DW-1:0] rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[HL_DW-1:0];
    endfunction

    function automatic logic pwr_out(input int m);
        return (m < FL_NUM) ? fl_pwr_b[m] : hl_pwr_b;
    endfunction

    // one strobe cycle, then idle.
    task access(input int m, input logic [MEM_AW-1:0] a, input logic we, input logic re,
                input logic [HL_DW-1:0] d);
        @(posedge clk);
        if (m < FL_NUM) begin
            fl_req[m] <= '{addr: a, we: we, re: re, wdata: d[FL_DW-1:0]};
        end else begin
            hl_req <= '{addr: a, we: we, re: re, wdata: d};
        end
        @(posedge clk);
        if (m < FL_NUM) begin
            fl_req[m] <= '0;
        end else begin
            hl_req <= '0;
        end
    endtask

    task set_pg(input int m, input logic isol, input logic pwr_b);
        @(posedge clk);
        if (m < FL_NUM) begin
            fl_pg[m] <= '{isol_en: isol, pwr_enable_b: pwr_b};
        end else begin
            hl_pg <= '{isol_en: isol, pwr_enable_b: pwr_b};
        end
    endtask

    task wait_pwr(input int m, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (pwr_out(m) !== level && n < 4 * PG_WAKE_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (pwr_out(m) !== level) begin
            $display("timeout: power-enable output of memory %0d never reached %0b", m, level);
            timeouts++;
        end
    endtask

    task end_test(input int id);
        @(posedge clk);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    // ==========================================================
    // test sequence.
    // ==========================================================

    initial begin
        logic [HL_DW-1:0] w;
        seed          = 32'h8f40_5730;
        rst           = 1'b1;
        pwrgood_rst_b = 1'b1;
        for (int m = 0; m < FL_NUM; m++) begin
            fl_req[m] = '0;
            fl_pg[m]  = '{isol_en: 1'b0, pwr_enable_b: 1'b1};
        end
        hl_req   = '0;
        hl_pg    = '{isol_en: 1'b0, pwr_enable_b: 1'b1};
        test_end = 1'b0;
        test_id  = 0;
        timeouts = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        repeat (2) @(posedge clk);
        end_test(1);

        for (int m = 0; m < FL_NUM + 1; m++) begin
            set_pg(m, 1'b0, 1'b0);
        end
        for (int m = 0; m < FL_NUM + 1; m++) begin
            wait_pwr(m, 1'b0);
        end
        set_pg(0, 1'b0, 1'b1);
        wait_pwr(0, 1'b1);
        set_pg(0, 1'b0, 1'b0);
        wait_pwr(0, 1'b0);
        end_test(2);

        for (int m = 0; m < FL_NUM + 1; m++) begin
            for (int i = 0; i < 8; i++) begin
                w           = rand_word();
                addrs[m][i] = w[MEM_AW-1:0];
                access(m, addrs[m][i], 1'b1, 1'b0, rand_word());
            end
            // same-cycle write and read.
            access(m, addrs[m][0], 1'b1, 1'b1, rand_word());
            for (int i = 0; i < 8; i++) begin
                access(m, addrs[m][i], 1'b0, 1'b1, '0);
                w = rand_word();
                access(m, w[MEM_AW-1:0], 1'b0, 1'b1, '0);
            end
        end
        end_test(3);

        for (int m = 1; m < FL_NUM + 1; m++) begin
            // held read word, so the clamp has data to hide.
            access(m, addrs[m][0], 1'b0, 1'b1, '0);
            set_pg(m, 1'b1, 1'b0);
            for (int i = 0; i < 4; i++) begin
                access(m, addrs[m][i], 1'b0, 1'b1, '0);
                access(m, addrs[m][i], 1'b1, 1'b0, rand_word());
            end
            set_pg(m, 1'b0, 1'b0);
            for (int i = 0; i < 4; i++) begin
                access(m, addrs[m][i], 1'b0, 1'b1, '0);
            end
        end
        end_test(4);

        access(0, addrs[0][0], 1'b0, 1'b1, '0);
        set_pg(0, 1'b0, 1'b1);
        wait_pwr(0, 1'b1);
        access(0, addrs[0][1], 1'b0, 1'b1, '0);
        set_pg(0, 1'b0, 1'b0);
        wait_pwr(0, 1'b0);
        for (int m = 0; m < FL_NUM + 1; m++) begin
            for (int i = 0; i < 8; i++) begin
                access(m, addrs[m][i], 1'b0, 1'b1, '0);
            end
        end
        end_test(5);

        // power-good reset while every memory is on.
        @(posedge clk);
        pwrgood_rst_b <= 1'b0;
        @(posedge clk);
        pwrgood_rst_b <= 1'b1;
        for (int m = 0; m < FL_NUM + 1; m++) begin
            wait_pwr(m, 1'b0);
        end
        end_test(6);

        repeat (2) @(posedge clk);
        $display("tests 6, checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
mem_cfg_pkg.sv
pg_pkg.sv
pg_switch_seq.sv
mem_pg_sram.sv
sram_pg_cont.sv
tb_checker.sv
tb_sram_pg_cont.sv

// ==== run.sh ====
#!/bin/sh
# build and run the list memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_sram_pg_cont -f all.f; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_sram_pg_cont 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
